// ==== rv_decode_config.svh ====
`ifndef RV_DECODE_CONFIG_SVH
`define RV_DECODE_CONFIG_SVH

// Fixed by the RV32I ISA
`define RV_XLEN       32  // Instruction and data width
`define RV_REG_ADDR_W 5   // x0..x31
`define RV_CSR_ADDR_W 12  // CSR space from instr[31:20]
`define RV_STRB_W     4   // One strobe per store byte

`endif

// ==== rv_decode_pkg.sv ====
`default_nettype none

`include "rv_decode_config.svh"

package rv_decode_pkg;

    // Major opcode class, resolved in the first stage
    typedef enum logic [3:0] {
        OPC_LUI,
        OPC_AUIPC,
        OPC_JAL,
        OPC_JALR,
        OPC_BRANCH,
        OPC_LOAD,
        OPC_STORE,
        OPC_OP_IMM,
        OPC_OP,
        OPC_FENCE,
        OPC_SYSTEM,
        OPC_ILLEGAL  // Any unknown 7-bit pattern
    } opcode_e;

    // ALU operation, same numbering the execution unit expects
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_op_e;

    // Load/store unit operation
    typedef enum logic [2:0] {
        LIS_LB  = 3'd0,
        LIS_LH  = 3'd1,
        LIS_LW  = 3'd2,
        LIS_LBU = 3'd3,
        LIS_LHU = 3'd4,
        LIS_SB  = 3'd5,
        LIS_SH  = 3'd6,
        LIS_SW  = 3'd7
    } lis_op_e;

    typedef enum logic [1:0] {
        BR_EQ,
        BR_NE,
        BR_LT,  // Signedness comes from the ALU op
        BR_GE
    } br_op_e;

    // Zero keeps the CSR unit idle
    typedef enum logic [2:0] {
        CSR_NONE   = 3'd0,
        CSR_RW     = 3'd1,
        CSR_RS     = 3'd2,
        CSR_RC     = 3'd3,
        CSR_RWI    = 3'd4,
        CSR_RSI    = 3'd5,
        CSR_RCI    = 3'd6
    } csr_op_e;

    // Operand sources at the execution unit
    typedef enum logic [1:0] {
        ORG_REGS,          // rs1 and rs2
        ORG_RS2IMM_RS1,    // Immediate in place of rs2
        ORG_RS2IMM_RS1PC   // Immediate and PC
    } data_origin_e;

    // What lands in rd
    typedef enum logic [1:0] {
        TGT_ALU_O,
        TGT_MEM_RD,
        TGT_PC_4,
        TGT_CSR
    } data_target_e;

    typedef enum logic [2:0] {
        IMM_NONE,
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J
    } imm_fmt_e;

    // Stage 1 output
    typedef struct packed {
        opcode_e                   opcode;
        logic [2:0]                funct3;
        logic                      funct7_b5;  // SUB and SRA select
        logic [`RV_REG_ADDR_W-1:0] rd;
        logic [`RV_REG_ADDR_W-1:0] rs1;
        logic [`RV_REG_ADDR_W-1:0] rs2;
        logic [24:0]               imm_bits;   // instr[31:7]
    } inst_fields_t;

    // Control word for the execution unit
    typedef struct packed {
        alu_op_e                   alu_op;
        lis_op_e                   lis_op;
        br_op_e                    br_op;
        csr_op_e                   csr_op;
        data_origin_e              data_origin;
        data_target_e              data_target;
        logic [`RV_XLEN-1:0]       imm_val;
        logic                      is_load_store;
        logic                      is_branch;
        logic                      is_conditional;
        logic                      mem_w;
        logic                      reg_w;
        logic [`RV_REG_ADDR_W-1:0] r1_addr;
        logic [`RV_REG_ADDR_W-1:0] r2_addr;
        logic [`RV_REG_ADDR_W-1:0] reg_addr;
        logic [`RV_STRB_W-1:0]     write_strb;
        logic [`RV_CSR_ADDR_W-1:0] csr_addr;
        logic [`RV_XLEN-1:0]       csr_data;
        logic                      illegal;
    } ctrl_word_t;

endpackage

`default_nettype wire

// ==== inst_field_stage.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "rv_decode_config.svh"

module inst_field_stage (
    input  logic                        clk_i,
    input  logic                        reset_i,
    input  logic                        instr_valid_i,
    input  logic [`RV_XLEN-1:0]         instr_i,
    output logic                        fields_valid_o,
    output rv_decode_pkg::inst_fields_t fields_o
);
    import rv_decode_pkg::*;

    opcode_e      opc_class;
    inst_fields_t fields_next;

    // Major opcode lookup, low two bits must be 11 for a 32-bit instruction
    always_comb begin
        unique case (instr_i[6:0])
            7'b0110111: opc_class = OPC_LUI;
            7'b0010111: opc_class = OPC_AUIPC;
            7'b1101111: opc_class = OPC_JAL;
            7'b1100111: opc_class = OPC_JALR;
            7'b1100011: opc_class = OPC_BRANCH;
            7'b0000011: opc_class = OPC_LOAD;
            7'b0100011: opc_class = OPC_STORE;
            7'b0010011: opc_class = OPC_OP_IMM;
            7'b0110011: opc_class = OPC_OP;
            7'b0001111: opc_class = OPC_FENCE;   // FENCE and FENCE.I
            7'b1110011: opc_class = OPC_SYSTEM;  // ECALL, EBREAK, CSR
            default:    opc_class = OPC_ILLEGAL;
        endcase
    end

    // Fixed RV32I field positions
    always_comb begin
        fields_next.opcode    = opc_class;
        fields_next.funct3    = instr_i[14:12];
        fields_next.funct7_b5 = instr_i[30];
        fields_next.rd        = instr_i[11:7];
        fields_next.rs1       = instr_i[19:15];
        fields_next.rs2       = instr_i[24:20];
        fields_next.imm_bits  = instr_i[31:7];  // Scattered immediate, rebuilt in stage 2
    end

    // Valid flag, cleared by reset
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            fields_valid_o <= 1'b0;
        end else begin
            fields_valid_o <= instr_valid_i;
        end
    end

    // Payload only loads on a valid cycle, bubbles leave it stale
    always_ff @(posedge clk_i) begin
        if (instr_valid_i) begin
            fields_o <= fields_next;
        end
    end

endmodule

`default_nettype wire

// ==== imm_gen.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "rv_decode_config.svh"

module imm_gen (
    input  rv_decode_pkg::imm_fmt_e imm_fmt_i,
    input  logic [24:0]             imm_bits_i,  // instr[31:7]
    output logic [`RV_XLEN-1:0]     imm_o
);
    import rv_decode_pkg::*;

    logic        sign;  // instr[31] in every signed format
    logic [11:0] imm_i;
    logic [11:0] imm_s;
    logic [12:0] imm_b;
    logic [20:0] imm_j;

    // Index n here is instr[n+7]
    assign sign  = imm_bits_i[24];
    assign imm_i = imm_bits_i[24:13];                       // instr[31:20]
    assign imm_s = {imm_bits_i[24:18], imm_bits_i[4:0]};    // instr[31:25], instr[11:7]
    assign imm_b = {imm_bits_i[24], imm_bits_i[0], imm_bits_i[23:18],
                    imm_bits_i[4:1], 1'b0};                 // Halfword aligned
    assign imm_j = {imm_bits_i[24], imm_bits_i[12:5], imm_bits_i[13],
                    imm_bits_i[23:14], 1'b0};               // instr[31|19:12|20|30:21]

    always_comb begin
        unique case (imm_fmt_i)
            IMM_I:   imm_o = {{(`RV_XLEN-12){sign}}, imm_i};
            IMM_S:   imm_o = {{(`RV_XLEN-12){sign}}, imm_s};
            IMM_B:   imm_o = {{(`RV_XLEN-13){sign}}, imm_b};
            IMM_U:   imm_o = {imm_bits_i[24:5], 12'b0};     // Upper 20, low 12 cleared
            IMM_J:   imm_o = {{(`RV_XLEN-21){sign}}, imm_j};
            default: imm_o = '0;                            // IMM_NONE
        endcase
    end

endmodule

`default_nettype wire

// ==== ctrl_decode_stage.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "rv_decode_config.svh"

module ctrl_decode_stage (
    input  logic                        clk_i,
    input  logic                        reset_i,
    input  logic                        fields_valid_i,
    input  rv_decode_pkg::inst_fields_t fields_i,
    output logic                        ctrl_valid_o,
    output rv_decode_pkg::ctrl_word_t   ctrl_o
);
    import rv_decode_pkg::*;

    imm_fmt_e            imm_fmt;
    logic [`RV_XLEN-1:0] imm_val;
    alu_op_e             alu_arith;   // OP and OP-IMM ALU op
    logic                bad_funct3;  // Reserved funct3 for the class
    ctrl_word_t          ctrl_dec;
    ctrl_word_t          ctrl_next;

    // Immediate format follows the opcode class alone
    always_comb begin
        unique case (fields_i.opcode)
            OPC_LUI, OPC_AUIPC:            imm_fmt = IMM_U;
            OPC_JAL:                       imm_fmt = IMM_J;
            OPC_JALR, OPC_LOAD, OPC_OP_IMM: imm_fmt = IMM_I;
            OPC_BRANCH:                    imm_fmt = IMM_B;
            OPC_STORE:                     imm_fmt = IMM_S;
            default:                       imm_fmt = IMM_NONE;  // OP, FENCE, SYSTEM
        endcase
    end

    imm_gen imm_gen_i (
        .imm_fmt_i  (imm_fmt),
        .imm_bits_i (fields_i.imm_bits),
        .imm_o      (imm_val)
    );

    // SUB only exists in OP, SRA in both
    always_comb begin
        unique case (fields_i.funct3)
            3'b000: begin
                if (fields_i.opcode == OPC_OP && fields_i.funct7_b5) begin
                    alu_arith = ALU_SUB;
                end else begin
                    alu_arith = ALU_ADD;
                end
            end
            3'b001:  alu_arith = ALU_SLL;
            3'b010:  alu_arith = ALU_SLT;
            3'b011:  alu_arith = ALU_SLTU;
            3'b100:  alu_arith = ALU_XOR;
            3'b101:  alu_arith = fields_i.funct7_b5 ? ALU_SRA : ALU_SRL;
            3'b110:  alu_arith = ALU_OR;
            default: alu_arith = ALU_AND;
        endcase
    end

    always_comb begin
        ctrl_dec   = '0;  // ADD, REGS, ALU_O, nothing written
        bad_funct3 = 1'b0;
        unique case (fields_i.opcode)
            OPC_LUI: begin
                ctrl_dec.data_origin = ORG_RS2IMM_RS1;  // x0 + imm
                ctrl_dec.imm_val     = imm_val;
                ctrl_dec.reg_w       = 1'b1;
                ctrl_dec.reg_addr    = fields_i.rd;
            end
            OPC_AUIPC: begin
                ctrl_dec.data_origin = ORG_RS2IMM_RS1PC;  // PC + imm
                ctrl_dec.imm_val     = imm_val;
                ctrl_dec.reg_w       = 1'b1;
                ctrl_dec.reg_addr    = fields_i.rd;
            end
            OPC_JAL: begin
                ctrl_dec.is_branch   = 1'b1;
                ctrl_dec.data_origin = ORG_RS2IMM_RS1PC;
                ctrl_dec.imm_val     = imm_val;
                ctrl_dec.reg_w       = 1'b1;
                ctrl_dec.reg_addr    = fields_i.rd;
                ctrl_dec.data_target = TGT_PC_4;  // Link address
            end
            OPC_JALR: begin
                ctrl_dec.is_branch   = 1'b1;
                ctrl_dec.data_origin = ORG_RS2IMM_RS1;  // rs1 + imm
                ctrl_dec.r1_addr     = fields_i.rs1;
                ctrl_dec.imm_val     = imm_val;
                ctrl_dec.reg_w       = 1'b1;
                ctrl_dec.reg_addr    = fields_i.rd;
                ctrl_dec.data_target = TGT_PC_4;
            end
            OPC_BRANCH: begin
                ctrl_dec.is_branch      = 1'b1;
                ctrl_dec.is_conditional = 1'b1;
                ctrl_dec.imm_val        = imm_val;  // Offset, ALU compares the registers
                ctrl_dec.r1_addr        = fields_i.rs1;
                ctrl_dec.r2_addr        = fields_i.rs2;
                unique case (fields_i.funct3)
                    3'b000: begin ctrl_dec.alu_op = ALU_SUB;  ctrl_dec.br_op = BR_EQ; end
                    3'b001: begin ctrl_dec.alu_op = ALU_SUB;  ctrl_dec.br_op = BR_NE; end
                    3'b100: begin ctrl_dec.alu_op = ALU_SLT;  ctrl_dec.br_op = BR_LT; end
                    3'b101: begin ctrl_dec.alu_op = ALU_SLT;  ctrl_dec.br_op = BR_GE; end
                    3'b110: begin ctrl_dec.alu_op = ALU_SLTU; ctrl_dec.br_op = BR_LT; end
                    3'b111: begin ctrl_dec.alu_op = ALU_SLTU; ctrl_dec.br_op = BR_GE; end
                    default: bad_funct3 = 1'b1;  // 010, 011
                endcase
            end
            OPC_LOAD: begin
                ctrl_dec.is_load_store = 1'b1;
                ctrl_dec.data_origin   = ORG_RS2IMM_RS1;  // Address rs1 + imm
                ctrl_dec.r1_addr       = fields_i.rs1;
                ctrl_dec.imm_val       = imm_val;
                ctrl_dec.reg_w         = 1'b1;
                ctrl_dec.reg_addr      = fields_i.rd;
                ctrl_dec.data_target   = TGT_MEM_RD;
                unique case (fields_i.funct3)
                    3'b000:  ctrl_dec.lis_op = LIS_LB;
                    3'b001:  ctrl_dec.lis_op = LIS_LH;
                    3'b010:  ctrl_dec.lis_op = LIS_LW;
                    3'b100:  ctrl_dec.lis_op = LIS_LBU;
                    3'b101:  ctrl_dec.lis_op = LIS_LHU;
                    default: bad_funct3 = 1'b1;  // 011, 110, 111
                endcase
            end
            OPC_STORE: begin
                ctrl_dec.is_load_store = 1'b1;
                ctrl_dec.mem_w         = 1'b1;
                ctrl_dec.data_origin   = ORG_RS2IMM_RS1;
                ctrl_dec.r1_addr       = fields_i.rs1;  // Base
                ctrl_dec.r2_addr       = fields_i.rs2;  // Store data
                ctrl_dec.imm_val       = imm_val;
                unique case (fields_i.funct3)
                    3'b000: begin ctrl_dec.lis_op = LIS_SB; ctrl_dec.write_strb = 4'b0001; end
                    3'b001: begin ctrl_dec.lis_op = LIS_SH; ctrl_dec.write_strb = 4'b0011; end
                    3'b010: begin ctrl_dec.lis_op = LIS_SW; ctrl_dec.write_strb = 4'b1111; end
                    default: bad_funct3 = 1'b1;
                endcase
            end
            OPC_OP_IMM: begin
                ctrl_dec.alu_op      = alu_arith;
                ctrl_dec.data_origin = ORG_RS2IMM_RS1;
                ctrl_dec.r1_addr     = fields_i.rs1;
                ctrl_dec.imm_val     = imm_val;  // Shamt sits in the low bits
                ctrl_dec.reg_w       = 1'b1;
                ctrl_dec.reg_addr    = fields_i.rd;
            end
            OPC_OP: begin
                ctrl_dec.alu_op   = alu_arith;
                ctrl_dec.r1_addr  = fields_i.rs1;
                ctrl_dec.r2_addr  = fields_i.rs2;
                ctrl_dec.reg_w    = 1'b1;
                ctrl_dec.reg_addr = fields_i.rd;
            end
            OPC_SYSTEM: begin
                if (fields_i.funct3 == 3'b100) begin
                    bad_funct3 = 1'b1;
                end else if (fields_i.funct3 != 3'b000) begin  // ECALL/EBREAK stay default
                    ctrl_dec.reg_w       = 1'b1;
                    ctrl_dec.reg_addr    = fields_i.rd;
                    ctrl_dec.csr_addr    = fields_i.imm_bits[24:13];  // instr[31:20]
                    ctrl_dec.data_target = TGT_CSR;
                    ctrl_dec.csr_data    = {{(`RV_XLEN-`RV_REG_ADDR_W){1'b0}}, fields_i.rs1};
                    unique case (fields_i.funct3)
                        3'b001:  ctrl_dec.csr_op = CSR_RW;
                        3'b010:  ctrl_dec.csr_op = CSR_RS;
                        3'b011:  ctrl_dec.csr_op = CSR_RC;
                        3'b101:  ctrl_dec.csr_op = CSR_RWI;
                        3'b110:  ctrl_dec.csr_op = CSR_RSI;
                        default: ctrl_dec.csr_op = CSR_RCI;
                    endcase
                end
            end
            default: ;  // FENCE is a no-op, ILLEGAL handled below
        endcase
    end

    // Illegal instructions collapse to the default word
    always_comb begin
        if (fields_i.opcode == OPC_ILLEGAL || bad_funct3) begin
            ctrl_next         = '0;
            ctrl_next.illegal = 1'b1;
        end else begin
            ctrl_next = ctrl_dec;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            ctrl_valid_o <= 1'b0;
        end else begin
            ctrl_valid_o <= fields_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (fields_valid_i) begin
            ctrl_o <= ctrl_next;  // Held through bubbles
        end
    end

endmodule

`default_nettype wire

// ==== rv_decoder_top.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "rv_decode_config.svh"

module rv_decoder_top (
    input  logic                      clk_i,
    input  logic                      reset_i,
    input  logic                      instr_valid_i,
    input  logic [`RV_XLEN-1:0]       instr_i,
    output logic                      ctrl_valid_o,
    output rv_decode_pkg::ctrl_word_t ctrl_o
);
    import rv_decode_pkg::*;

    logic         fields_valid;  // Stage 1 to stage 2
    inst_fields_t fields;

    // Field split and opcode class
    inst_field_stage inst_field_stage_i (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .instr_valid_i  (instr_valid_i),
        .instr_i        (instr_i),
        .fields_valid_o (fields_valid),
        .fields_o       (fields)
    );

    // Control word, output two cycles after the instruction
    ctrl_decode_stage ctrl_decode_stage_i (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .fields_valid_i (fields_valid),
        .fields_i       (fields),
        .ctrl_valid_o   (ctrl_valid_o),
        .ctrl_o         (ctrl_o)
    );

endmodule

`default_nettype wire

// ==== decode_checker.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "rv_decode_config.svh"

module decode_checker (
    input  logic                      clk_i,
    input  logic                      reset_i,
    input  logic                      instr_valid_i,
    input  logic [`RV_XLEN-1:0]       instr_i,
    input  logic                      ctrl_valid_i,  // DUT ctrl_valid_o
    input  rv_decode_pkg::ctrl_word_t ctrl_i,
    input  string                     test_name_i,
    output int                        err_count_o,
    output int                        check_count_o,
    output int                        pending_o
);
    import rv_decode_pkg::*;

    logic [`RV_XLEN-1:0] sent_q[$];  // Valid inputs still in flight
    logic [`RV_XLEN-1:0] head;
    ctrl_word_t          expected;
    logic                exp_v1 = 1'b0;  // Valid one stage deep
    logic                exp_v2 = 1'b0;  // Valid as the output should show it
    int                  errors = 0;
    int                  checks = 0;
    int                  pushed = 0;
    int                  popped = 0;

    assign err_count_o   = errors;
    assign check_count_o = checks;
    assign pending_o     = pushed - popped;

    function automatic alu_op_e arith_op(input logic [2:0] f3, input logic sub_ok,
                                         input logic b30);
        case (f3)
            3'b000:  arith_op = (sub_ok && b30) ? ALU_SUB : ALU_ADD;
            3'b001:  arith_op = ALU_SLL;
            3'b010:  arith_op = ALU_SLT;
            3'b011:  arith_op = ALU_SLTU;
            3'b100:  arith_op = ALU_XOR;
            3'b101:  arith_op = b30 ? ALU_SRA : ALU_SRL;
            3'b110:  arith_op = ALU_OR;
            default: arith_op = ALU_AND;
        endcase
    endfunction

    // Reference decode straight from the raw instruction bits
    function automatic ctrl_word_t model_decode(input logic [31:0] ins);
        ctrl_word_t w;
        logic [2:0] f3;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic       bad;
        w   = '0;
        f3  = ins[14:12];
        rd  = ins[11:7];
        rs1 = ins[19:15];
        rs2 = ins[24:20];
        bad = 1'b0;
        case (ins[6:0])
            7'b0110111, 7'b0010111: begin  // LUI, AUIPC
                w.data_origin = ins[5] ? ORG_RS2IMM_RS1 : ORG_RS2IMM_RS1PC;
                w.imm_val     = {ins[31:12], 12'h000};
                w.reg_w       = 1'b1;
                w.reg_addr    = rd;
            end
            7'b1101111: begin  // JAL
                w.is_branch   = 1'b1;
                w.data_origin = ORG_RS2IMM_RS1PC;
                w.imm_val     = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
                w.reg_w       = 1'b1;
                w.reg_addr    = rd;
                w.data_target = TGT_PC_4;
            end
            7'b1100111: begin  // JALR
                w.is_branch   = 1'b1;
                w.data_origin = ORG_RS2IMM_RS1;
                w.r1_addr     = rs1;
                w.imm_val     = {{20{ins[31]}}, ins[31:20]};
                w.reg_w       = 1'b1;
                w.reg_addr    = rd;
                w.data_target = TGT_PC_4;
            end
            7'b1100011: begin
                w.is_branch      = 1'b1;
                w.is_conditional = 1'b1;
                w.imm_val        = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
                w.r1_addr        = rs1;
                w.r2_addr        = rs2;
                bad              = (f3 == 3'b010) || (f3 == 3'b011);
                w.br_op          = f3[0] ? (f3[2] ? BR_GE : BR_NE) : (f3[2] ? BR_LT : BR_EQ);
                w.alu_op         = !f3[2] ? ALU_SUB : (f3[1] ? ALU_SLTU : ALU_SLT);
            end
            7'b0000011: begin
                w.is_load_store = 1'b1;
                w.data_origin   = ORG_RS2IMM_RS1;
                w.r1_addr       = rs1;
                w.imm_val       = {{20{ins[31]}}, ins[31:20]};
                w.reg_w         = 1'b1;
                w.reg_addr      = rd;
                w.data_target   = TGT_MEM_RD;
                case (f3)
                    3'b000:  w.lis_op = LIS_LB;
                    3'b001:  w.lis_op = LIS_LH;
                    3'b010:  w.lis_op = LIS_LW;
                    3'b100:  w.lis_op = LIS_LBU;
                    3'b101:  w.lis_op = LIS_LHU;
                    default: bad = 1'b1;
                endcase
            end
            7'b0100011: begin
                w.is_load_store = 1'b1;
                w.mem_w         = 1'b1;
                w.data_origin   = ORG_RS2IMM_RS1;
                w.r1_addr       = rs1;
                w.r2_addr       = rs2;
                w.imm_val       = {{20{ins[31]}}, ins[31:25], ins[11:7]};
                case (f3)
                    3'b000:  w.lis_op = LIS_SB;
                    3'b001:  w.lis_op = LIS_SH;
                    3'b010:  w.lis_op = LIS_SW;
                    default: bad = 1'b1;
                endcase
                w.write_strb = (f3 == 3'b000) ? 4'b0001 : ((f3 == 3'b001) ? 4'b0011 : 4'b1111);
            end
            7'b0010011: begin  // OP-IMM, no SUB here
                w.alu_op      = arith_op(f3, 1'b0, ins[30]);
                w.data_origin = ORG_RS2IMM_RS1;
                w.r1_addr     = rs1;
                w.imm_val     = {{20{ins[31]}}, ins[31:20]};
                w.reg_w       = 1'b1;
                w.reg_addr    = rd;
            end
            7'b0110011: begin
                w.alu_op   = arith_op(f3, 1'b1, ins[30]);
                w.r1_addr  = rs1;
                w.r2_addr  = rs2;
                w.reg_w    = 1'b1;
                w.reg_addr = rd;
            end
            7'b1110011: begin
                bad = (f3 == 3'b100);
                if (f3 != 3'b000) begin  // ECALL and EBREAK keep the default word
                    w.reg_w       = 1'b1;
                    w.reg_addr    = rd;
                    w.csr_addr    = ins[31:20];
                    w.data_target = TGT_CSR;
                    w.csr_data    = {27'b0, rs1};
                    case (f3)
                        3'b001:  w.csr_op = CSR_RW;
                        3'b010:  w.csr_op = CSR_RS;
                        3'b011:  w.csr_op = CSR_RC;
                        3'b101:  w.csr_op = CSR_RWI;
                        3'b110:  w.csr_op = CSR_RSI;
                        default: w.csr_op = CSR_RCI;
                    endcase
                end
            end
            7'b0001111: ;  // FENCE
            default: bad = 1'b1;
        endcase
        if (bad) begin
            w         = '0;
            w.illegal = 1'b1;
        end
        model_decode = w;
    endfunction

    // Registered outputs read here still hold last cycle's value
    always @(posedge clk_i) begin
        if (!reset_i) begin
            if (ctrl_valid_i !== exp_v2) begin
                errors++;
                if (ctrl_valid_i === 1'b1 && sent_q.size() == 0) begin
                    $display("Test %0s: ctrl_valid_o rose with no instruction in flight",
                             test_name_i);
                end else if (ctrl_valid_i === 1'b1) begin
                    $display("Test %0s: ctrl_valid_o high without an input two cycles before",
                             test_name_i);
                end else begin
                    $display("Test %0s: ctrl_valid_o missing two cycles after a valid input",
                             test_name_i);
                end
            end
            if (ctrl_valid_i === 1'b1 && sent_q.size() != 0) begin
                head     = sent_q.pop_front();
                popped++;
                expected = model_decode(head);
                checks++;
                if (ctrl_i !== expected) begin
                    errors++;
                    $display("ERROR test %0s: instr %h expected %h actual %h",
                             test_name_i, head, expected, ctrl_i);
                end
            end
        end
        exp_v2 = reset_i ? 1'b0 : exp_v1;
        exp_v1 = reset_i ? 1'b0 : instr_valid_i;
        if (!reset_i && instr_valid_i) begin
            sent_q.push_back(instr_i);
            pushed++;
        end
    end

endmodule

`default_nettype wire

// ==== tb_rv_decoder.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "rv_decode_config.svh"

module tb_rv_decoder;
    import rv_decode_pkg::*;

    localparam int NUM_TESTS      = 5;
    localparam int INSTR_PER_TEST = 300;
    // Room for bubbles (one in eight on average) plus the pipeline drain
    localparam int TIMEOUT_CYCLES = NUM_TESTS * (INSTR_PER_TEST + INSTR_PER_TEST / 4 + 8) + 50;

    localparam logic [2:0] LOAD_F3 [5] = '{3'b000, 3'b001, 3'b010, 3'b100, 3'b101};
    localparam logic [2:0] BR_F3   [6] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
    localparam logic [2:0] CSR_F3  [6] = '{3'b001, 3'b010, 3'b011, 3'b101, 3'b110, 3'b111};
    // Reserved {opcode, funct3} pairs
    localparam logic [9:0] BAD_OPF3 [11] = '{
        {7'b1100011, 3'b010}, {7'b1100011, 3'b011},
        {7'b0000011, 3'b011}, {7'b0000011, 3'b110}, {7'b0000011, 3'b111},
        {7'b0100011, 3'b011}, {7'b0100011, 3'b100}, {7'b0100011, 3'b101},
        {7'b0100011, 3'b110}, {7'b0100011, 3'b111}, {7'b1110011, 3'b100}
    };

    logic                clk = 1'b0;
    logic                reset;
    logic                instr_valid;
    logic [`RV_XLEN-1:0] instr;
    logic                ctrl_valid;
    ctrl_word_t          ctrl;
    string               test_name;
    int                  err_count;
    int                  check_count;
    int                  pending;
    integer              seed = 34224;
    int                  cycles = 0;

    always #20 clk = ~clk;  // 40 ns period

    rv_decoder_top rv_decoder_top_i (
        .clk_i         (clk),
        .reset_i       (reset),
        .instr_valid_i (instr_valid),
        .instr_i       (instr),
        .ctrl_valid_o  (ctrl_valid),
        .ctrl_o        (ctrl)
    );

    decode_checker decode_checker_i (
        .clk_i         (clk),
        .reset_i       (reset),
        .instr_valid_i (instr_valid),
        .instr_i       (instr),
        .ctrl_valid_i  (ctrl_valid),
        .ctrl_i        (ctrl),
        .test_name_i   (test_name),
        .err_count_o   (err_count),
        .check_count_o (check_count),
        .pending_o     (pending)
    );

    function automatic logic [31:0] rand_word();
        rand_word = $random(seed);
    endfunction

    function automatic int pick(input int n);
        pick = rand_word() % n;
    endfunction

    function automatic logic [31:0] alu_instr();
        logic [31:0] w;
        w = rand_word();
        if (w[0]) begin
            w[31:25] = {1'b0, w[30], 5'b0};  // OP uses funct7 bit 5 only
            w[6:0]   = 7'b0110011;
        end else begin
            w[6:0] = 7'b0010011;
        end
        alu_instr = w;
    endfunction

    function automatic logic [31:0] mem_instr();
        logic [31:0] w;
        w = rand_word();
        if (w[0]) begin
            w[6:0]   = 7'b0000011;
            w[14:12] = LOAD_F3[pick(5)];
        end else begin
            w[6:0]   = 7'b0100011;
            w[14:12] = LOAD_F3[pick(3)];  // SB, SH, SW share the first three
        end
        mem_instr = w;
    endfunction

    function automatic logic [31:0] flow_instr();
        logic [31:0] w;
        w = rand_word();
        case (pick(5))
            0:       w[6:0] = 7'b0110111;
            1:       w[6:0] = 7'b0010111;
            2:       w[6:0] = 7'b1101111;
            3:       w[14:0] = {3'b000, w[11:7], 7'b1100111};  // JALR
            default: w[14:0] = {BR_F3[pick(6)], w[11:7], 7'b1100011};
        endcase
        flow_instr = w;
    endfunction

    function automatic logic [31:0] sys_instr();
        logic [31:0] w;
        w = rand_word();
        case (pick(4))
            0, 1:    w[14:0] = {CSR_F3[pick(6)], w[11:7], 7'b1110011};
            2:       w[6:0] = 7'b0001111;  // FENCE
            default: w = w[20] ? 32'h0010_0073 : 32'h0000_0073;  // EBREAK or ECALL
        endcase
        sys_instr = w;
    endfunction

    function automatic logic [31:0] bad_instr();
        logic [31:0] w;
        w = rand_word();
        if (pick(2) != 0) begin
            {w[6:0], w[14:12]} = BAD_OPF3[pick(11)];
        end
        bad_instr = w;
    endfunction

    function automatic logic [31:0] next_instr(input int id);
        case (id)
            0:       next_instr = alu_instr();
            1:       next_instr = mem_instr();
            2:       next_instr = flow_instr();
            3:       next_instr = sys_instr();
            default: next_instr = bad_instr();
        endcase
    endfunction

    function automatic string test_label(input int id);
        case (id)
            0:       test_label = "alu_ops";
            1:       test_label = "load_store";
            2:       test_label = "control_flow";
            3:       test_label = "csr_nop";
            default: test_label = "illegal_stream";
        endcase
    endfunction

    task automatic run_test(input int id);
        int errs_before;
        int checks_before;
        int sent;
        errs_before   = err_count;
        checks_before = check_count;
        sent          = 0;
        test_name     = test_label(id);
        while (sent < INSTR_PER_TEST) begin
            @(negedge clk);
            if (pick(8) == 0) begin
                instr_valid = 1'b0;
                instr       = rand_word();  // Junk on a bubble
            end else begin
                instr_valid = 1'b1;
                instr       = next_instr(id);
                sent++;
            end
        end
        @(negedge clk);
        instr_valid = 1'b0;
        while (pending != 0) begin
            @(negedge clk);  // Drain until the checker has seen every output
        end
        $display("Test %0s: %0d checks, %0d errors", test_name,
                 check_count - checks_before, err_count - errs_before);
    endtask

    initial begin
        reset       = 1'b1;
        instr_valid = 1'b1;  // Valid held high through reset
        instr       = rand_word();
        test_name   = "reset";
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset       = 1'b0;
        instr_valid = 1'b0;
        repeat (2) @(negedge clk);  // Output valid stays low while idle
        $display("Test %0s: %0d errors", test_name, err_count);
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        $display("Summary: %0d tests, %0d checks, %0d errors", NUM_TESTS, check_count,
                 err_count);
        if (err_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, decoder outputs never drained", cycles);
            $display("Finished with errors");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+.
rv_decode_pkg.sv
inst_field_stage.sv
imm_gen.sv
ctrl_decode_stage.sv
rv_decoder_top.sv
decode_checker.sv
tb_rv_decoder.sv

// ==== Makefile ====
.PHONY: sim clean

# Build with Verilator, run, then look for the pass line in the log
sim:
	verilator --binary --timing -f compile.f --top-module tb_rv_decoder -o sim_rv_decoder
	./obj_dir/sim_rv_decoder | tee sim.log
	grep -q "^Finished with no errors" sim.log

clean:
	rm -rf obj_dir sim.log
